// File: common/audio_pkg.sv
package audio_pkg;

    // sample and coefficient formats
    localparam int pcm_w  = 24;   // pcm sample width
    localparam int coef_w = 16;   // coef q1.15, gain q4.12
    localparam int acc_w  = 48;   // fir accumulator

    // filter bank shape
    localparam int num_bands   = 2;
    localparam int num_taps    = 4;
    localparam int num_coefs   = num_bands * num_taps;
    localparam int band_w      = $clog2(num_bands);
    localparam int tap_w       = $clog2(num_taps);
    localparam int coef_addr_w = 3;   // {band, tap}
    localparam int eq_sel_w    = 8;   // band select field of the eq register

    // i2s framing
    localparam int slot_bits = 24;                   // bits per channel slot
    localparam int bclk_div  = 4;                    // clk per half bclk
    localparam int div_cnt_w = $clog2(bclk_div);
    localparam int bit_cnt_w = $clog2(slot_bits + 1); // wide enough for pcm_w too

    // fixed point
    localparam int fir_shift = 15;   // drop q1.15 fraction
    localparam int eq_shift  = 12;   // drop q4.12 fraction

    localparam logic signed [acc_w-1:0] pcm_max = acc_w'((1 << (pcm_w - 1)) - 1);
    localparam logic signed [acc_w-1:0] pcm_min = -pcm_max - 1;

    // clamp a wide signed value into pcm range
    function automatic logic [pcm_w-1:0] sat_pcm(input logic signed [acc_w-1:0] x);
        if (x > pcm_max)
            return pcm_max[pcm_w-1:0];
        if (x < pcm_min)
            return pcm_min[pcm_w-1:0];
        return x[pcm_w-1:0];
    endfunction

endpackage

// File: common/ctrl_pkg.sv
package ctrl_pkg;

    // audio_control register bits
    localparam int ctrl_w       = 8;
    localparam int ctl_bypass   = 0;   // input lines straight to dac
    localparam int ctl_enable   = 1;   // run the filter path
    localparam int ctl_coef_clr = 2;   // rising edge zeroes coef memory

    localparam int aud_en_dly = 2;     // clk from enable to filtering

    // coef memory owner for one cycle
    typedef enum logic [1:0] {
        grant_none,
        grant_fir,
        grant_cpu,
        grant_clr
    } arb_grant_e;

    // fir engine sequence
    typedef enum logic [1:0] {
        st_idle,    // wait for sample_stb
        st_load,    // coef read requested
        st_mac,     // coef_q valid, accumulate both channels
        st_store    // shift, saturate, next band
    } fir_state_e;

endpackage

// File: hw/i2s_rx.sv
`timescale 1ns/1ps

module i2s_rx import audio_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             bclk,
    input  logic             lrclk,
    input  logic             sdata,
    output logic [pcm_w-1:0] l_pcm,
    output logic [pcm_w-1:0] r_pcm,
    output logic             pcm_stb
);

    logic [2:0]           bclk_s;    // 2 sync stages + edge history
    logic [1:0]           lr_s;
    logic [1:0]           d_s;
    logic                 bclk_rise;
    logic                 lr_d;      // lrclk one bclk ago, owns the current bit
    logic                 lr_dd;     // lrclk two bclks ago
    logic [bit_cnt_w-1:0] bit_cnt;   // bits taken for this word
    logic [pcm_w-1:0]     sh;
    logic [pcm_w-1:0]     word;      // word incl. the bit being taken

    assign bclk_rise = bclk_s[1] & ~bclk_s[2];
    assign word      = {sh[pcm_w-2:0], d_s[1]};

    always_ff @(posedge clk) begin
        if (rst) begin
            bclk_s  <= '0;
            lr_s    <= '0;
            d_s     <= '0;
            lr_d    <= 1'b0;
            lr_dd   <= 1'b0;
            bit_cnt <= bit_cnt_w'(pcm_w);   // parked until the first lrclk change
            pcm_stb <= 1'b0;
        end else begin
            bclk_s  <= {bclk_s[1:0], bclk};
            lr_s    <= {lr_s[0], lrclk};
            d_s     <= {d_s[0], sdata};
            pcm_stb <= 1'b0;

            if (bclk_rise) begin
                lr_d  <= lr_s[1];
                lr_dd <= lr_d;
                if (lr_d != lr_dd) begin
                    // msb, one bclk after the lrclk change
                    sh      <= {{(pcm_w - 1){1'b0}}, d_s[1]};
                    bit_cnt <= bit_cnt_w'(1);
                end else if (bit_cnt < bit_cnt_w'(pcm_w)) begin
                    sh      <= word;
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == bit_cnt_w'(pcm_w - 1)) begin   // lsb taken
                        if (lr_d) begin
                            r_pcm   <= word;
                            pcm_stb <= 1'b1;   // right closes the frame
                        end else begin
                            l_pcm <= word;
                        end
                    end
                end
            end
        end
    end

endmodule

// File: hw/i2s_tx.sv
`timescale 1ns/1ps

module i2s_tx import audio_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic [pcm_w-1:0] l_pcm,
    input  logic [pcm_w-1:0] r_pcm,
    input  logic             pcm_stb,
    output logic             bclk,
    output logic             lrclk,
    output logic             sdata
);

    logic [div_cnt_w-1:0] div_cnt;
    logic [bit_cnt_w-1:0] bit_cnt;      // bclk periods into the slot
    logic [pcm_w-1:0]     l_hold;       // last mix result
    logic [pcm_w-1:0]     r_hold;
    logic [pcm_w-1:0]     r_frame;      // right word of the running frame
    logic [pcm_w-1:0]     sh;
    logic                 tick;
    logic                 bclk_fall;

    assign tick      = (div_cnt == div_cnt_w'(bclk_div - 1));
    assign bclk_fall = tick & bclk;     // lrclk and data move on falling bclk

    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
            bit_cnt <= '0;
            bclk    <= 1'b0;
            lrclk   <= 1'b0;
            sdata   <= 1'b0;
            l_hold  <= '0;
            r_hold  <= '0;
            r_frame <= '0;
            sh      <= '0;
        end else begin
            if (pcm_stb) begin   // newest words win
                l_hold <= l_pcm;
                r_hold <= r_pcm;
            end

            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (tick)
                bclk <= ~bclk;

            if (bclk_fall) begin
                sdata <= sh[pcm_w-1];   // old lsb leaves on the lrclk edge
                if (bit_cnt == bit_cnt_w'(slot_bits - 1)) begin
                    bit_cnt <= '0;
                    lrclk   <= ~lrclk;
                    if (lrclk) begin
                        // frame start, take both words together
                        sh      <= l_hold;
                        r_frame <= r_hold;
                    end else begin
                        sh <= r_frame;
                    end
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                    sh      <= {sh[pcm_w-2:0], 1'b0};
                end
            end
        end
    end

endmodule

// File: fir/coef_store.sv
`timescale 1ns/1ps

module coef_store import audio_pkg::*, ctrl_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fir_rd,
    input  logic [coef_addr_w-1:0] fir_addr,
    output logic                   fir_gnt,
    output logic [coef_w-1:0]      coef_q,
    input  logic                   coef_wr,
    input  logic [coef_addr_w-1:0] coef_addr,
    input  logic [coef_w-1:0]      coef_wdata,
    input  logic                   coef_clr
);

    logic [coef_w-1:0]      mem [num_coefs];   // single port
    logic                   pend_vld;          // one-deep cpu write slot
    logic [coef_addr_w-1:0] pend_addr;
    logic [coef_w-1:0]      pend_data;
    logic                   clr_q;
    logic                   clr_active;
    logic [coef_addr_w-1:0] clr_cnt;
    arb_grant_e             gnt;

    ////////////////////////////////////////////////////////////////////////////
    // arbiter: fir read > clear > cpu write

    always_comb begin
        if (fir_rd)
            gnt = grant_fir;
        else if (clr_active)
            gnt = grant_clr;
        else if (pend_vld)
            gnt = grant_cpu;
        else
            gnt = grant_none;
    end

    assign fir_gnt = (gnt == grant_fir);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_coefs; i++)
                mem[i] <= '0;
            coef_q     <= '0;
            pend_vld   <= 1'b0;
            clr_q      <= 1'b0;
            clr_active <= 1'b0;
            clr_cnt    <= '0;
        end else begin
            case (gnt)
                grant_fir: coef_q <= mem[fir_addr];   // valid next cycle
                grant_clr: begin
                    mem[clr_cnt] <= '0;
                    clr_cnt      <= clr_cnt + 1'b1;
                    if (clr_cnt == coef_addr_w'(num_coefs - 1))
                        clr_active <= 1'b0;
                end
                grant_cpu: begin
                    mem[pend_addr] <= pend_data;
                    pend_vld       <= 1'b0;
                end
                default: ;
            endcase

            if (coef_wr) begin   // overwrites a slot still waiting
                pend_vld  <= 1'b1;
                pend_addr <= coef_addr;
                pend_data <= coef_wdata;
            end

            clr_q <= coef_clr;
            if (coef_clr && !clr_q) begin   // restart on every rising edge
                clr_active <= 1'b1;
                clr_cnt    <= '0;
            end
        end
    end

endmodule

// File: fir/fir_bank.sv
`timescale 1ns/1ps

module fir_bank import audio_pkg::*, ctrl_pkg::*; (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           sample_stb,
    input  logic [pcm_w-1:0]               x_l,
    input  logic [pcm_w-1:0]               x_r,
    output logic                           fir_rd,
    output logic [coef_addr_w-1:0]         fir_addr,
    input  logic                           fir_gnt,
    input  logic [coef_w-1:0]              coef_q,
    output logic [num_bands*pcm_w-1:0]     band_l,
    output logic [num_bands*pcm_w-1:0]     band_r,
    output logic                           band_stb
);

    fir_state_e              state;
    logic [band_w-1:0]       band_idx;
    logic [tap_w-1:0]        tap_idx;
    logic signed [pcm_w-1:0] dl_l [num_taps];   // [0] is the newest sample
    logic signed [pcm_w-1:0] dl_r [num_taps];
    logic signed [acc_w-1:0] acc_l;
    logic signed [acc_w-1:0] acc_r;

    assign fir_rd   = (state == st_load);
    assign fir_addr = coef_addr_w'({band_idx, tap_idx});

    ////////////////////////////////////////////////////////////////////////////
    // sequencer and delay lines

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            band_idx <= '0;
            tap_idx  <= '0;
            band_stb <= 1'b0;
            for (int i = 0; i < num_taps; i++) begin
                dl_l[i] <= '0;
                dl_r[i] <= '0;
            end
        end else begin
            band_stb <= 1'b0;
            case (state)
                st_idle: if (sample_stb) begin   // busy strobes are dropped
                    for (int i = num_taps - 1; i > 0; i--) begin
                        dl_l[i] <= dl_l[i-1];
                        dl_r[i] <= dl_r[i-1];
                    end
                    dl_l[0]  <= x_l;
                    dl_r[0]  <= x_r;
                    band_idx <= '0;
                    tap_idx  <= '0;
                    state    <= st_load;
                end
                st_load: if (fir_gnt)
                    state <= st_mac;
                st_mac: begin
                    tap_idx <= tap_idx + 1'b1;   // wraps to 0 after last tap
                    state   <= (tap_idx == tap_w'(num_taps - 1)) ? st_store : st_load;
                end
                st_store: begin
                    if (band_idx == band_w'(num_bands - 1)) begin
                        band_stb <= 1'b1;
                        state    <= st_idle;
                    end else begin
                        band_idx <= band_idx + 1'b1;
                        state    <= st_load;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // mac datapath, one coef read serves both channels

    always_ff @(posedge clk) begin
        case (state)
            st_idle: begin
                acc_l <= '0;
                acc_r <= '0;
            end
            st_mac: begin
                acc_l <= acc_l + $signed(coef_q) * dl_l[tap_idx];
                acc_r <= acc_r + $signed(coef_q) * dl_r[tap_idx];
            end
            st_store: begin
                band_l[band_idx*pcm_w +: pcm_w] <= sat_pcm(acc_l >>> fir_shift);
                band_r[band_idx*pcm_w +: pcm_w] <= sat_pcm(acc_r >>> fir_shift);
                acc_l <= '0;   // fresh sum for next band
                acc_r <= '0;
            end
            default: ;
        endcase
    end

endmodule

// File: hw/eq_mixer.sv
`timescale 1ns/1ps

module eq_mixer import audio_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [num_bands*pcm_w-1:0] band_l,
    input  logic [num_bands*pcm_w-1:0] band_r,
    input  logic                       band_stb,
    input  logic                       eq_wr,
    input  logic [eq_sel_w-1:0]        eq_sel,
    input  logic [coef_w-1:0]          eq_gain,
    output logic [pcm_w-1:0]           mix_l,
    output logic [pcm_w-1:0]           mix_r,
    output logic                       mix_stb
);

    logic signed [coef_w-1:0] gain [num_bands];   // q4.12 per band
    logic signed [acc_w-1:0]  wsum_l;
    logic signed [acc_w-1:0]  wsum_r;
    logic signed [acc_w-1:0]  sum_l;              // stage 1 result
    logic signed [acc_w-1:0]  sum_r;
    logic                     sum_vld;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int b = 0; b < num_bands; b++)
                gain[b] <= '0;
        end else if (eq_wr && eq_sel < eq_sel_w'(num_bands)) begin   // out of range ignored
            gain[eq_sel[band_w-1:0]] <= eq_gain;
        end
    end

    // weighted band sum per channel
    always_comb begin
        wsum_l = '0;
        wsum_r = '0;
        for (int b = 0; b < num_bands; b++) begin
            wsum_l = wsum_l + $signed(band_l[b*pcm_w +: pcm_w]) * gain[b];
            wsum_r = wsum_r + $signed(band_r[b*pcm_w +: pcm_w]) * gain[b];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sum_vld <= 1'b0;
            mix_stb <= 1'b0;
        end else begin
            sum_vld <= band_stb;
            mix_stb <= sum_vld;   // band_stb + 2
        end
    end

    always_ff @(posedge clk) begin
        if (band_stb) begin
            sum_l <= wsum_l;
            sum_r <= wsum_r;
        end
        if (sum_vld) begin   // drop q4.12 fraction, clamp
            mix_l <= sat_pcm(sum_l >>> eq_shift);
            mix_r <= sat_pcm(sum_r >>> eq_shift);
        end
    end

endmodule

// File: hw/audio_proc_top.sv
`timescale 1ns/1ps

module audio_proc_top import audio_pkg::*, ctrl_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    // i2s from the codec
    input  logic                   i2s_bclk,
    input  logic                   i2s_lrclk,
    input  logic                   i2s_d,
    // i2s toward the dac
    output logic                   dac_rst,
    output logic                   dac_bclk,
    output logic                   dac_lrclk,
    output logic                   dac_data,
    // register values
    input  logic [ctrl_w-1:0]      audio_control,
    input  logic                   coef_wr,
    input  logic [coef_addr_w-1:0] coef_addr,
    input  logic [coef_w-1:0]      coef_wdata,
    input  logic                   eq_wr,
    input  logic [eq_sel_w-1:0]    eq_sel,
    input  logic [coef_w-1:0]      eq_gain
);

    logic [pcm_w-1:0]           l_pcm, r_pcm;
    logic                       pcm_stb;
    logic [aud_en_dly-1:0]      en_dly;       // enable delay line
    logic                       sample_stb;
    logic                       fir_rd, fir_gnt;
    logic [coef_addr_w-1:0]     fir_addr;
    logic [coef_w-1:0]          coef_q;
    logic [num_bands*pcm_w-1:0] band_l, band_r;
    logic                       band_stb;
    logic [pcm_w-1:0]           mix_l, mix_r;
    logic                       mix_stb;
    logic                       tx_bclk, tx_lrclk, tx_data;

    assign dac_rst    = rst;
    assign sample_stb = pcm_stb & en_dly[aud_en_dly-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            en_dly    <= '0;
            dac_bclk  <= 1'b0;
            dac_lrclk <= 1'b0;
            dac_data  <= 1'b0;
        end else begin
            en_dly <= {en_dly[aud_en_dly-2:0], audio_control[ctl_enable]};
            if (audio_control[ctl_bypass]) begin   // raw input, one clk late
                dac_bclk  <= i2s_bclk;
                dac_lrclk <= i2s_lrclk;
                dac_data  <= i2s_d;
            end else begin
                dac_bclk  <= tx_bclk;
                dac_lrclk <= tx_lrclk;
                dac_data  <= tx_data;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // audio path

    i2s_rx u_i2s_rx (
        .clk(clk), .rst(rst),
        .bclk(i2s_bclk), .lrclk(i2s_lrclk), .sdata(i2s_d),
        .l_pcm(l_pcm), .r_pcm(r_pcm), .pcm_stb(pcm_stb)
    );

    fir_bank u_fir_bank (
        .clk(clk), .rst(rst),
        .sample_stb(sample_stb), .x_l(l_pcm), .x_r(r_pcm),
        .fir_rd(fir_rd), .fir_addr(fir_addr), .fir_gnt(fir_gnt), .coef_q(coef_q),
        .band_l(band_l), .band_r(band_r), .band_stb(band_stb)
    );

    coef_store u_coef_store (
        .clk(clk), .rst(rst),
        .fir_rd(fir_rd), .fir_addr(fir_addr), .fir_gnt(fir_gnt), .coef_q(coef_q),
        .coef_wr(coef_wr), .coef_addr(coef_addr), .coef_wdata(coef_wdata),
        .coef_clr(audio_control[ctl_coef_clr])
    );

    eq_mixer u_eq_mixer (
        .clk(clk), .rst(rst),
        .band_l(band_l), .band_r(band_r), .band_stb(band_stb),
        .eq_wr(eq_wr), .eq_sel(eq_sel), .eq_gain(eq_gain),
        .mix_l(mix_l), .mix_r(mix_r), .mix_stb(mix_stb)
    );

    i2s_tx u_i2s_tx (
        .clk(clk), .rst(rst),
        .l_pcm(mix_l), .r_pcm(mix_r), .pcm_stb(mix_stb),
        .bclk(tx_bclk), .lrclk(tx_lrclk), .sdata(tx_data)
    );

endmodule

// File: bench/tb_audio_proc.sv
`timescale 1ns/1ps

module tb_audio_proc import audio_pkg::*; ();

    localparam int clk_half   = 4;            // 8 ns clock
    localparam int frame_clks = 384;          // 48 bclk of 8 clk
    localparam int n_chk      = 8;            // checked words per stream
    localparam int n_flush    = 4;            // extra frames to drain the path
    localparam int n_streams  = 7;
    localparam int wd_limit   = n_streams * (n_chk + n_flush + 2) * frame_clks * 8 * 2;

    logic        clk = 1'b0;
    logic        rst;
    logic        i2s_bclk, i2s_lrclk, i2s_d;
    logic        dac_rst, dac_bclk, dac_lrclk, dac_data;
    logic [7:0]  audio_control;
    logic        coef_wr, eq_wr;
    logic [2:0]  coef_addr;
    logic [15:0] coef_wdata, eq_gain;
    logic [7:0]  eq_sel;

    logic [31:0] lfsr = 32'd75368;
    logic        carry;                        // right lsb, sent in next frame
    logic        model_en;
    logic        byp_chk;
    logic [2:0]  wr_addr;                      // mid-stream coef write
    logic [15:0] wr_data;
    int          n_checks, n_errors, err_mark;

    // model state
    logic [15:0] mdl_coef [num_coefs];
    logic [15:0] mdl_gain [num_bands];
    longint      dl_l [num_taps];
    longint      dl_r [num_taps];
    logic [23:0] exp_l [$];
    logic [23:0] exp_r [$];
    bit          exp_skip [$];

    // dac decoder state
    logic [23:0] dec_l [$];
    logic [23:0] dec_r [$];
    logic [23:0] dec_sh, dec_left;
    logic        dec_bclk_q, dec_lr1, dec_lr2;
    int          dec_cnt;
    logic [2:0]  in_hist;                     // input lines one clk ago

    always #(clk_half) clk = ~clk;

    audio_proc_top i_dut (
        .clk(clk), .rst(rst),
        .i2s_bclk(i2s_bclk), .i2s_lrclk(i2s_lrclk), .i2s_d(i2s_d),
        .dac_rst(dac_rst), .dac_bclk(dac_bclk), .dac_lrclk(dac_lrclk), .dac_data(dac_data),
        .audio_control(audio_control),
        .coef_wr(coef_wr), .coef_addr(coef_addr), .coef_wdata(coef_wdata),
        .eq_wr(eq_wr), .eq_sel(eq_sel), .eq_gain(eq_gain)
    );

    ////////////////////////////////////////////////////////////////////////////
    // random source and model

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic longint clamp24(input longint x);
        if (x > 64'sd8388607)
            return 64'sd8388607;
        if (x < -64'sd8388608)
            return -64'sd8388608;
        return x;
    endfunction

    // one stereo frame through delay line, fir bands and eq sum
    task automatic model_frame(input logic [23:0] l, input logic [23:0] r);
        longint acc_l, acc_r, sum_l, sum_r, c, g;
        for (int i = num_taps - 1; i > 0; i--) begin
            dl_l[i] = dl_l[i-1];
            dl_r[i] = dl_r[i-1];
        end
        dl_l[0] = longint'($signed(l));
        dl_r[0] = longint'($signed(r));
        sum_l = 0;
        sum_r = 0;
        for (int b = 0; b < num_bands; b++) begin
            acc_l = 0;
            acc_r = 0;
            for (int t = 0; t < num_taps; t++) begin
                c = longint'($signed(mdl_coef[b*num_taps + t]));
                acc_l += c * dl_l[t];
                acc_r += c * dl_r[t];
            end
            g = longint'($signed(mdl_gain[b]));
            sum_l += clamp24(acc_l >>> 15) * g;   // q1.15 product back to pcm
            sum_r += clamp24(acc_r >>> 15) * g;
        end
        exp_l.push_back(24'(clamp24(sum_l >>> 12)));   // q4.12 gain
        exp_r.push_back(24'(clamp24(sum_r >>> 12)));
        exp_skip.push_back(1'b0);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // i2s encoder and register writes

    // one bclk period, data already delayed one bclk by the caller
    task automatic drive_bit(input logic lr, input logic d, input logic wr);
        @(posedge clk);
        i2s_bclk   <= 1'b0;
        i2s_lrclk  <= lr;
        i2s_d      <= d;
        coef_wr    <= wr;
        coef_addr  <= wr_addr;
        coef_wdata <= wr_data;
        @(posedge clk);
        coef_wr <= 1'b0;
        repeat (2) @(posedge clk);
        @(posedge clk);
        i2s_bclk <= 1'b1;
        repeat (3) @(posedge clk);
    endtask

    task automatic send_frame(input logic [23:0] l, input logic [23:0] r, input logic wr);
        logic d;
        for (int p = 0; p < 48; p++) begin
            if (p == 0)
                d = carry;
            else if (p < 24)
                d = l[24-p];
            else if (p == 24)
                d = l[0];
            else
                d = r[48-p];
            drive_bit(p >= 24, d, wr && (p == 24));   // write lands mid frame
        end
        carry = r[0];
    endtask

    task automatic set_ctrl(input logic [7:0] v);
        @(posedge clk);
        audio_control <= v;
        repeat (4) @(posedge clk);
    endtask

    task automatic write_coef(input logic [2:0] a, input logic [15:0] d);
        @(posedge clk);
        coef_wr    <= 1'b1;
        coef_addr  <= a;
        coef_wdata <= d;
        @(posedge clk);
        coef_wr <= 1'b0;
        repeat (4) @(posedge clk);
        mdl_coef[a] = d;
    endtask

    task automatic write_gain(input int b, input logic [15:0] d);
        @(posedge clk);
        eq_wr   <= 1'b1;
        eq_sel  <= 8'(b);
        eq_gain <= d;
        @(posedge clk);
        eq_wr <= 1'b0;
        repeat (2) @(posedge clk);
        mdl_gain[b] = d;
    endtask

    // stream frames, optional coef write during frame wr_at
    task automatic run_stream(input int wr_at);
        logic [23:0] l, r;
        exp_l.delete();
        exp_r.delete();
        exp_skip.delete();
        dec_l.delete();
        dec_r.delete();
        for (int k = 0; k < n_chk + n_flush; k++) begin
            l = 24'(rand_bits(24));
            r = 24'(rand_bits(24));
            if (k == wr_at) begin
                mdl_coef[wr_addr] = wr_data;
                exp_skip[k-1] = 1'b1;   // frame around the write
            end
            if (model_en)
                model_frame(l, r);
            send_frame(l, r, k == wr_at);
        end
        drive_bit(1'b1, carry, 1'b0);   // last right lsb
        repeat (frame_clks) @(posedge clk);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // checks

    task automatic compare_stream();
        int base;
        bit hit;
        base = -1;
        // first offset where every checked word lines up
        for (int i = 0; i < dec_l.size() && base < 0; i++) begin
            hit = (i + n_chk <= dec_l.size());
            for (int j = 0; j < n_chk && hit; j++)
                if (!exp_skip[j] && (dec_l[i+j] != exp_l[j] || dec_r[i+j] != exp_r[j]))
                    hit = 1'b0;
            if (hit)
                base = i;
        end
        // else the first word alone, mismatches get listed
        for (int i = 0; i < dec_l.size(); i++)
            if (base < 0 && dec_l[i] == exp_l[0] && dec_r[i] == exp_r[0])
                base = i;
        n_checks++;
        assert (base >= 0) else begin
            $display("no decoded dac word matches the first expected word at %0d ns", $time);
            n_errors++;
        end
        if (base >= 0) begin
            for (int j = 0; j < n_chk; j++) begin
                n_checks++;
                if (base + j >= dec_l.size()) begin
                    $display("dac stream ended after %0d of %0d words", j, n_chk);
                    n_errors++;
                    break;
                end
                if (!exp_skip[j])
                    assert (dec_l[base+j] == exp_l[j] && dec_r[base+j] == exp_r[j]) else begin
                        $display("[FAIL] %0d ns: word %0d got %06h/%06h expected %06h/%06h",
                                 $time, j, dec_l[base+j], dec_r[base+j], exp_l[j], exp_r[j]);
                        n_errors++;
                    end
            end
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %-26s %s, %0d errors", name,
                 (n_errors == err_mark) ? "ok" : "failed", n_errors - err_mark);
        err_mark = n_errors;
    endtask

    // decode dac lines, bit owned by the lrclk of the previous bclk
    always @(posedge clk) begin
        if (dac_bclk && !dec_bclk_q) begin
            if (dec_lr1 != dec_lr2) begin
                dec_sh  = {23'd0, dac_data};   // msb
                dec_cnt = 1;
            end else if (dec_cnt < 24) begin
                dec_sh  = {dec_sh[22:0], dac_data};
                dec_cnt = dec_cnt + 1;
                if (dec_cnt == 24 && dec_lr1) begin
                    dec_l.push_back(dec_left);
                    dec_r.push_back(dec_sh);
                end else if (dec_cnt == 24) begin
                    dec_left = dec_sh;
                end
            end
            dec_lr2 = dec_lr1;
            dec_lr1 = dac_lrclk;
        end
        dec_bclk_q = dac_bclk;
    end

    // dac reset follows rst, bypass lines one clk behind the inputs
    always @(posedge clk) begin
        n_checks++;
        assert (dac_rst == rst) else begin
            $display("[FAIL] %0d ns: dac_rst %b while rst %b", $time, dac_rst, rst);
            n_errors++;
        end
        if (byp_chk) begin
            n_checks++;
            assert ({dac_bclk, dac_lrclk, dac_data} == in_hist) else begin
                $display("[FAIL] %0d ns: bypass dac lines %b expected %b", $time,
                         {dac_bclk, dac_lrclk, dac_data}, in_hist);
                n_errors++;
            end
        end
        in_hist <= {i2s_bclk, i2s_lrclk, i2s_d};
    end

    initial begin
        #(wd_limit * 1ns);
        $display("watchdog: run did not finish within %0d ns", wd_limit);
        $display("** FAIL **");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        rst = 1'b1;
        i2s_bclk = 1'b0;
        i2s_lrclk = 1'b1;   // idle in a right slot
        i2s_d = 1'b0;
        audio_control = '0;
        coef_wr = 1'b0;
        coef_addr = '0;
        coef_wdata = '0;
        eq_wr = 1'b0;
        eq_sel = '0;
        eq_gain = '0;
        carry = 1'b0;
        model_en = 1'b0;
        byp_chk = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        n_checks = 0;
        n_errors = 0;
        err_mark = 0;
        dec_cnt = 24;
        dec_sh = '0;
        dec_left = '0;      // tx starts in a zero left slot
        dec_bclk_q = 1'b0;
        dec_lr1 = 1'b0;
        dec_lr2 = 1'b0;
        for (int i = 0; i < num_coefs; i++)
            mdl_coef[i] = '0;
        for (int b = 0; b < num_bands; b++)
            mdl_gain[b] = '0;
        for (int t = 0; t < num_taps; t++) begin
            dl_l[t] = 0;
            dl_r[t] = 0;
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);
        repeat (3) drive_bit(1'b1, 1'b0, 1'b0);

        // filter path off, only zero words
        write_coef(3'd0, 16'h7fff);   // a running filter would pass the input
        write_gain(0, 16'h1000);
        run_stream(-1);
        n_checks++;
        assert (dec_l.size() > 0) else begin
            $display("no dac words decoded while the filter path was off");
            n_errors++;
        end
        for (int i = 0; i < dec_l.size(); i++) begin
            n_checks++;
            assert (dec_l[i] == 24'd0 && dec_r[i] == 24'd0) else begin
                $display("[FAIL] %0d ns: word %0d is %06h/%06h, expected zero",
                         $time, i, dec_l[i], dec_r[i]);
                n_errors++;
            end
        end
        finish_test("enable low");

        set_ctrl(8'h01);
        byp_chk = 1'b1;
        run_stream(-1);
        byp_chk = 1'b0;
        set_ctrl(8'h00);
        finish_test("bypass");

        set_ctrl(8'h02);
        model_en = 1'b1;
        write_coef(3'd0, 16'h7fff);
        write_gain(0, 16'h1000);   // unity
        run_stream(-1);
        compare_stream();
        finish_test("single tap unity");

        for (int a = 0; a < num_coefs; a++)
            write_coef(3'(a), 16'(rand_bits(16)));
        write_gain(0, 16'(rand_bits(16)));
        write_gain(1, 16'(rand_bits(16)));
        run_stream(-1);
        compare_stream();
        write_gain(0, 16'h7fff);   // forces clipping
        write_gain(1, 16'h7fff);
        run_stream(-1);
        compare_stream();
        finish_test("random fir and mix");

        write_gain(0, 16'h0800);   // half each, sum stays out of clipping
        write_gain(1, 16'h0800);
        wr_addr = 3'(rand_bits(3));
        wr_data = 16'(rand_bits(16));
        run_stream(4);
        compare_stream();
        finish_test("coef write while streaming");

        set_ctrl(8'h06);
        set_ctrl(8'h02);
        repeat (16) @(posedge clk);
        for (int i = 0; i < num_coefs; i++)
            mdl_coef[i] = '0;
        run_stream(-1);
        compare_stream();
        finish_test("coef clear");

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// File: sources.f
common/audio_pkg.sv
common/ctrl_pkg.sv
hw/i2s_rx.sv
hw/i2s_tx.sv
fir/coef_store.sv
fir/fir_bank.sv
hw/eq_mixer.sv
hw/audio_proc_top.sv
bench/tb_audio_proc.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_audio_proc \
    -f sources.f -Mdir obj_dir

./obj_dir/Vtb_audio_proc | tee sim.log

if grep -q '\*\* PASS \*\*' sim.log; then
    exit 0
else
    exit 1
fi
